// ==== hdl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // ----------------------------------------------------------------------
    // Counter encoding
    // ----------------------------------------------------------------------
    // Two-bit saturating counters, top bit is the prediction
    localparam int CTR_W = 2;

    // Weakly not-taken, or weakly prefer local for the choice table
    localparam logic [CTR_W-1:0] CTR_INIT = 2'd1;

    localparam logic [CTR_W-1:0] CTR_MAX = {CTR_W{1'b1}};

    // ----------------------------------------------------------------------
    // Default sizes
    // ----------------------------------------------------------------------
    localparam int DEF_ADDR_WIDTH  = 32;
    localparam int DEF_GHR_WIDTH   = 8;
    localparam int DEF_BHT_ENTRIES = 256;
    localparam int DEF_PHT_ENTRIES = 256;
    localparam int DEF_SEL_ENTRIES = 256;
    localparam int DEF_BTB_ENTRIES = 64;

    // Move a counter one step toward up/down, holding at both ends
    function automatic logic [CTR_W-1:0] ctr_step(input logic [CTR_W-1:0] ctr,
                                                  input logic             up);
        logic [CTR_W-1:0] ctr_next;
        ctr_next = ctr;
        if (up) begin
            if (ctr != CTR_MAX) ctr_next = ctr + 1'b1;
        end else begin
            if (ctr != '0) ctr_next = ctr - 1'b1;
        end
        return ctr_next;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/local_predictor.sv ====
`default_nettype none

module local_predictor #(
    parameter int ADDR_WIDTH  = bp_pkg::DEF_ADDR_WIDTH,
    parameter int BHT_ENTRIES = bp_pkg::DEF_BHT_ENTRIES
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Lookup
    input  wire logic [ADDR_WIDTH-1:0] pc_i,
    output logic                       pred_o,

    // Resolved branch
    input  wire logic                  upd_valid_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire logic                  upd_taken_i,
    output logic                       upd_pred_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    logic [CTR_W-1:0] bht_q [BHT_ENTRIES];

    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] upd_idx;

    // Word-aligned PC, so indexing starts at bit 2
    assign look_idx = pc_i[IDX_W+1:2];
    assign upd_idx  = upd_pc_i[IDX_W+1:2];

    assign pred_o = bht_q[look_idx][CTR_W-1];

    // Old prediction at the update slot, used by choice training
    assign upd_pred_o = bht_q[upd_idx][CTR_W-1];

    // ----------------------------------------------------------------------
    // Counter training
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht_q[i] <= CTR_INIT;
            end
        end else if (upd_valid_i) begin
            bht_q[upd_idx] <= ctr_step(bht_q[upd_idx], upd_taken_i);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/global_predictor.sv ====
`default_nettype none

module global_predictor #(
    parameter int ADDR_WIDTH  = bp_pkg::DEF_ADDR_WIDTH,
    parameter int GHR_WIDTH   = bp_pkg::DEF_GHR_WIDTH,
    parameter int PHT_ENTRIES = bp_pkg::DEF_PHT_ENTRIES
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Lookup
    input  wire logic [ADDR_WIDTH-1:0] pc_i,
    output logic                       pred_o,

    // Resolved branch
    input  wire logic                  upd_valid_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire logic                  upd_taken_i,
    output logic                       upd_pred_o,

    // Current history, shared with the choice table
    output logic [GHR_WIDTH-1:0]       ghr_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(PHT_ENTRIES);

    logic [GHR_WIDTH-1:0] ghr_q;
    logic [CTR_W-1:0]     pht_q [PHT_ENTRIES];

    logic [IDX_W-1:0] ghr_fold;
    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] upd_idx;

    // History zero-extended or truncated to the index width
    assign ghr_fold = IDX_W'(ghr_q);

    // Lookup and update both use the committed history
    assign look_idx = pc_i[IDX_W+1:2] ^ ghr_fold;
    assign upd_idx  = upd_pc_i[IDX_W+1:2] ^ ghr_fold;

    assign pred_o     = pht_q[look_idx][CTR_W-1];
    assign upd_pred_o = pht_q[upd_idx][CTR_W-1];
    assign ghr_o      = ghr_q;

    // ----------------------------------------------------------------------
    // History register
    // ----------------------------------------------------------------------
    // Newest outcome enters at bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (upd_valid_i) begin
            ghr_q <= {ghr_q[GHR_WIDTH-2:0], upd_taken_i};
        end
    end

    // ----------------------------------------------------------------------
    // Pattern table training
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_INIT;
            end
        end else if (upd_valid_i) begin
            pht_q[upd_idx] <= ctr_step(pht_q[upd_idx], upd_taken_i);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/choice_predictor.sv ====
`default_nettype none

module choice_predictor #(
    parameter int ADDR_WIDTH  = bp_pkg::DEF_ADDR_WIDTH,
    parameter int GHR_WIDTH   = bp_pkg::DEF_GHR_WIDTH,
    parameter int SEL_ENTRIES = bp_pkg::DEF_SEL_ENTRIES
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Lookup
    input  wire logic [ADDR_WIDTH-1:0] pc_i,
    input  wire logic [GHR_WIDTH-1:0]  ghr_i,
    input  wire logic                  local_pred_i,
    input  wire logic                  global_pred_i,
    input  wire logic                  btb_hit_i,
    output logic                       pred_taken_o,

    // Resolved branch
    input  wire logic                  upd_valid_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire logic                  upd_taken_i,
    input  wire logic                  upd_local_pred_i,
    input  wire logic                  upd_global_pred_i
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(SEL_ENTRIES);

    logic [CTR_W-1:0] sel_q [SEL_ENTRIES];

    logic [IDX_W-1:0] ghr_fold;
    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] upd_idx;
    logic             use_global;
    logic             local_ok;
    logic             global_ok;

    assign ghr_fold = IDX_W'(ghr_i);
    assign look_idx = pc_i[IDX_W+1:2] ^ ghr_fold;
    assign upd_idx  = upd_pc_i[IDX_W+1:2] ^ ghr_fold;

    // Top bit set means trust global
    assign use_global = sel_q[look_idx][CTR_W-1];

    // Never predict taken without a target to go to
    assign pred_taken_o = btb_hit_i & (use_global ? global_pred_i : local_pred_i);

    // ----------------------------------------------------------------------
    // Choice training
    // ----------------------------------------------------------------------
    assign local_ok  = (upd_local_pred_i == upd_taken_i);
    assign global_ok = (upd_global_pred_i == upd_taken_i);

    // Only a disagreement in correctness moves the counter,
    // toward whichever side was right
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < SEL_ENTRIES; i++) begin
                sel_q[i] <= CTR_INIT;
            end
        end else if (upd_valid_i && (local_ok != global_ok)) begin
            sel_q[upd_idx] <= ctr_step(sel_q[upd_idx], global_ok);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_target_buffer.sv ====
`default_nettype none

module branch_target_buffer #(
    parameter int ADDR_WIDTH  = bp_pkg::DEF_ADDR_WIDTH,
    parameter int BTB_ENTRIES = bp_pkg::DEF_BTB_ENTRIES
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Lookup
    input  wire logic [ADDR_WIDTH-1:0] pc_i,
    output logic                       hit_o,
    output logic [ADDR_WIDTH-1:0]      target_o,

    // Resolved branch
    input  wire logic                  upd_valid_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_target_i
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    logic                  valid_q  [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0] tag_q    [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0] target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] upd_idx;

    assign look_idx = pc_i[IDX_W+1:2];
    assign upd_idx  = upd_pc_i[IDX_W+1:2];

    // ----------------------------------------------------------------------
    // Lookup
    // ----------------------------------------------------------------------
    // Full PC kept as tag, so aliases never hit
    assign hit_o    = valid_q[look_idx] && (tag_q[look_idx] == pc_i);
    assign target_o = target_q[look_idx];

    // ----------------------------------------------------------------------
    // Fill
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // Every update overwrites its slot, replacing any alias
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            tag_q[upd_idx]    <= upd_pc_i;
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tournament_predictor.sv ====
`default_nettype none

module tournament_predictor #(
    parameter int ADDR_WIDTH  = bp_pkg::DEF_ADDR_WIDTH,
    parameter int GHR_WIDTH   = bp_pkg::DEF_GHR_WIDTH,
    parameter int BHT_ENTRIES = bp_pkg::DEF_BHT_ENTRIES,
    parameter int PHT_ENTRIES = bp_pkg::DEF_PHT_ENTRIES,
    parameter int SEL_ENTRIES = bp_pkg::DEF_SEL_ENTRIES,
    parameter int BTB_ENTRIES = bp_pkg::DEF_BTB_ENTRIES
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Fetch side lookup
    input  wire logic [ADDR_WIDTH-1:0] pc_i,
    output logic                       pred_taken_o,
    output logic [ADDR_WIDTH-1:0]      pred_target_o,
    output logic                       btb_hit_o,

    // Resolved branch, one per strobe
    input  wire logic                  upd_valid_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire logic                  upd_taken_i,
    input  wire logic [ADDR_WIDTH-1:0] upd_target_i
);

    logic                 local_pred;
    logic                 upd_local_pred;
    logic                 global_pred;
    logic                 upd_global_pred;
    logic [GHR_WIDTH-1:0] ghr;
    logic                 btb_hit;
    logic [ADDR_WIDTH-1:0] btb_target;

    assign btb_hit_o     = btb_hit;
    assign pred_target_o = btb_target;

    // ----------------------------------------------------------------------
    // Direction predictors
    // ----------------------------------------------------------------------
    local_predictor #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .BHT_ENTRIES (BHT_ENTRIES)
    ) local_predictor_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .pc_i        (pc_i),
        .pred_o      (local_pred),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i),
        .upd_pred_o  (upd_local_pred)
    );

    global_predictor #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .GHR_WIDTH   (GHR_WIDTH),
        .PHT_ENTRIES (PHT_ENTRIES)
    ) global_predictor_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .pc_i        (pc_i),
        .pred_o      (global_pred),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i),
        .upd_pred_o  (upd_global_pred),
        .ghr_o       (ghr)
    );

    choice_predictor #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .GHR_WIDTH   (GHR_WIDTH),
        .SEL_ENTRIES (SEL_ENTRIES)
    ) choice_predictor_inst (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .pc_i              (pc_i),
        .ghr_i             (ghr),
        .local_pred_i      (local_pred),
        .global_pred_i     (global_pred),
        .btb_hit_i         (btb_hit),
        .pred_taken_o      (pred_taken_o),
        .upd_valid_i       (upd_valid_i),
        .upd_pc_i          (upd_pc_i),
        .upd_taken_i       (upd_taken_i),
        .upd_local_pred_i  (upd_local_pred),
        .upd_global_pred_i (upd_global_pred)
    );

    // ----------------------------------------------------------------------
    // Target store
    // ----------------------------------------------------------------------
    branch_target_buffer #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) branch_target_buffer_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pc_i         (pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_target_i (upd_target_i)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released just after an edge, clear of the sampling point
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_tournament_predictor.sv ====
`default_nettype none

module tb_tournament_predictor;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 20;
    localparam int          ADDR_W     = 32;
    localparam logic [31:0] RAND_SEED  = 32'h4207_a310;

    // A and B share BTB slot 0
    // D sits at local index 2 and F at local index 15 and BTB slot 7
    localparam logic [31:0] PC_A  = 32'h0000_1000;
    localparam logic [31:0] PC_B  = 32'h0000_1020;
    localparam logic [31:0] PC_C  = 32'h0000_2004;
    localparam logic [31:0] PC_D  = 32'h0000_3008;
    localparam logic [31:0] PC_F  = 32'h0000_503c;
    localparam logic [31:0] TGT_A = 32'h0000_1100;
    localparam logic [31:0] TGT_B = 32'h0000_1200;
    localparam logic [31:0] TGT_C = 32'h0000_2400;
    localparam logic [31:0] TGT_D = 32'h0000_3300;
    localparam logic [31:0] TGT_F = 32'h0000_5500;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] pc;
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_target;
    logic              btb_hit;
    logic              upd_valid;
    logic [ADDR_W-1:0] upd_pc;
    logic              upd_taken;
    logic [ADDR_W-1:0] upd_target;

    // Stimulus and expected values with one entry per cycle
    logic        upd_valid_q  [$];
    logic [31:0] upd_pc_q     [$];
    logic        upd_taken_q  [$];
    logic [31:0] upd_target_q [$];
    logic [31:0] look_pc_q    [$];
    logic        exp_taken_q  [$];
    logic        exp_hit_q    [$];
    logic [31:0] exp_target_q [$];

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) tb_clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    tournament_predictor #(
        .ADDR_WIDTH  (ADDR_W),
        .GHR_WIDTH   (4),
        .BHT_ENTRIES (16),
        .PHT_ENTRIES (16),
        .SEL_ENTRIES (16),
        .BTB_ENTRIES (8)
    ) tournament_predictor_inst (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .pc_i          (pc),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .btb_hit_o     (btb_hit),
        .upd_valid_i   (upd_valid),
        .upd_pc_i      (upd_pc),
        .upd_taken_i   (upd_taken),
        .upd_target_i  (upd_target)
    );

    task automatic add_row(input logic v, input logic [31:0] u_pc, input logic u_taken,
                           input logic [31:0] u_tgt, input logic [31:0] l_pc,
                           input logic e_taken, input logic e_hit, input logic [31:0] e_tgt);
        upd_valid_q.push_back(v);
        upd_pc_q.push_back(u_pc);
        upd_taken_q.push_back(u_taken);
        upd_target_q.push_back(u_tgt);
        look_pc_q.push_back(l_pc);
        exp_taken_q.push_back(e_taken);
        exp_hit_q.push_back(e_hit);
        exp_target_q.push_back(e_tgt);
    endtask

    task automatic add_lookup(input logic [31:0] l_pc, input logic e_taken,
                              input logic e_hit, input logic [31:0] e_tgt);
        add_row(1'b0, 32'h0, 1'b0, 32'h0, l_pc, e_taken, e_hit, e_tgt);
    endtask

    // ----------------------------------------------------------------------
    // Test table
    // ----------------------------------------------------------------------
    // Each lookup sees the state left by all earlier rows
    task automatic build_table();
        // Empty BTB after reset
        add_lookup(PC_A, 1'b0, 1'b0, 32'h0);
        add_lookup(PC_B, 1'b0, 1'b0, 32'h0);
        add_lookup(PC_C, 1'b0, 1'b0, 32'h0);
        // BTB fill and alias replacement
        add_row(1'b1, PC_A, 1'b0, TGT_A, PC_A, 1'b0, 1'b0, 32'h0);
        add_lookup(PC_A, 1'b0, 1'b1, TGT_A);
        add_lookup(PC_B, 1'b0, 1'b0, 32'h0);
        add_row(1'b1, PC_B, 1'b0, TGT_B, PC_B, 1'b0, 1'b0, 32'h0);
        add_lookup(PC_B, 1'b0, 1'b1, TGT_B);
        add_lookup(PC_A, 1'b0, 1'b0, 32'h0);
        // Local training on C while the choice still prefers local
        add_row(1'b1, PC_C, 1'b1, TGT_C, PC_C, 1'b0, 1'b0, 32'h0);
        add_lookup(PC_C, 1'b1, 1'b1, TGT_C);
        add_row(1'b1, PC_C, 1'b1, TGT_C, PC_C, 1'b1, 1'b1, TGT_C);
        add_row(1'b1, PC_C, 1'b1, TGT_C, PC_C, 1'b1, 1'b1, TGT_C);
        add_row(1'b1, PC_C, 1'b0, TGT_C, PC_C, 1'b1, 1'b1, TGT_C);
        add_lookup(PC_C, 1'b1, 1'b1, TGT_C);
        add_row(1'b1, PC_C, 1'b0, TGT_C, PC_C, 1'b1, 1'b1, TGT_C);
        add_lookup(PC_C, 1'b0, 1'b1, TGT_C);
        add_row(1'b1, PC_C, 1'b0, TGT_C, PC_C, 1'b0, 1'b1, TGT_C);
        // Past saturation at zero
        add_row(1'b1, PC_C, 1'b0, TGT_C, PC_C, 1'b0, 1'b1, TGT_C);
        add_lookup(PC_C, 1'b0, 1'b1, TGT_C);
        // One taken only reaches weakly not-taken
        add_row(1'b1, PC_C, 1'b1, TGT_C, PC_C, 1'b0, 1'b1, TGT_C);
        add_lookup(PC_C, 1'b0, 1'b1, TGT_C);
        // D alternates N and T so the history settles at 5 before N and 10 before T
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b0, 32'h0);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        // Global right and local wrong moves choice entry 8 to 2
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        // Now follows global counter 8
        add_lookup(PC_D, 1'b1, 1'b1, TGT_D);
        // F shifts the history from 10 to 4 so the same PC reaches global counter 6
        add_row(1'b1, PC_F, 1'b0, TGT_F, PC_D, 1'b1, 1'b1, TGT_D);
        add_lookup(PC_D, 1'b0, 1'b1, TGT_D);
        add_lookup(PC_F, 1'b0, 1'b1, TGT_F);
        // Walk history back to 10
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        // Local right and global wrong while the lookup still shows the old state
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b1, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b1, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        add_row(1'b1, PC_D, 1'b0, TGT_D, PC_D, 1'b0, 1'b1, TGT_D);
        // Back at history 10 where choice entry 8 prefers local again
        add_lookup(PC_D, 1'b0, 1'b1, TGT_D);
        add_lookup(PC_B, 1'b0, 1'b1, TGT_B);
        add_lookup(PC_C, 1'b0, 1'b1, TGT_C);
    endtask

    // ----------------------------------------------------------------------
    // Timeout
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        pc         = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
        void'($urandom(RAND_SEED));
        build_table();
        cycle_limit = exp_taken_q.size() * 2 + 20;

        @(posedge rst_n);
        for (int i = 0; i < exp_taken_q.size(); i++) begin
            @(posedge clk);
            #2;
            upd_valid = upd_valid_q[i];
            upd_pc    = upd_pc_q[i];
            upd_taken = upd_taken_q[i];
            // Target is a don't care without a strobe
            if (upd_valid_q[i]) begin
                upd_target = upd_target_q[i];
            end else begin
                upd_target = $urandom();
            end
            pc = look_pc_q[i];

            // Sample just before the next edge
            #(CLK_PERIOD - 4);
            check_count = check_count + 1;
            if (btb_hit !== exp_hit_q[i]) begin
                $display("[ERROR] row %0d btb_hit_o: got %h expected %h",
                         i, btb_hit, exp_hit_q[i]);
                error_count = error_count + 1;
            end
            if (pred_taken !== exp_taken_q[i]) begin
                $display("[ERROR] row %0d pred_taken_o: got %h expected %h",
                         i, pred_taken, exp_taken_q[i]);
                error_count = error_count + 1;
            end
            if (exp_hit_q[i] && (pred_target !== exp_target_q[i])) begin
                $display("[ERROR] row %0d pred_target_o: got %h expected %h",
                         i, pred_target, exp_target_q[i]);
                error_count = error_count + 1;
            end
        end

        $display("Rows checked: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/bp_pkg.sv
hdl/local_predictor.sv
hdl/global_predictor.sv
hdl/choice_predictor.sv
hdl/branch_target_buffer.sv
hdl/tournament_predictor.sv
testbench/tb_clock_gen.sv
testbench/tb_tournament_predictor.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_tournament_predictor
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on a nonzero exit status or when the log reports failure
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
